//--- logic/backend_pkg.sv
// Back end package
// Sizes, opcode encoding and the structs that travel between
// dispatch, the issue FIFOs, both execution lanes and writeback.

package backend_pkg;

	localparam int XLEN       = 32;
	localparam int NUM_REGS   = 16;
	localparam int REG_AW     = 4;
	localparam int FIFO_DEPTH = 4;
	localparam int MUL_STAGES = 3;

	// FIFO pointer and occupancy widths
	localparam int FIFO_PW = $clog2(FIFO_DEPTH);
	localparam int FIFO_CW = $clog2(FIFO_DEPTH + 1);

	typedef logic [XLEN-1:0]   xlen_t;
	typedef logic [REG_AW-1:0] reg_addr_t;

	typedef enum logic [2:0] {
		OP_ADD  = 3'd0,
		OP_SUB  = 3'd1,
		OP_AND  = 3'd2,
		OP_OR   = 3'd3,
		OP_XOR  = 3'd4,
		OP_SLL  = 3'd5,
		OP_MUL  = 3'd6,
		OP_MULH = 3'd7
	} op_e;

	// Operands already resolved upstream
	typedef struct packed {
		op_e       op;
		reg_addr_t rd;
		xlen_t     op_a;
		xlen_t     op_b;
	} micro_op_t;

	typedef struct packed {
		logic      valid;
		reg_addr_t rd;
		xlen_t     data;
	} wb_t;

	// Multiply pipeline payload, one per stage
	typedef struct packed {
		reg_addr_t         rd;
		logic              hi;
		logic [2*XLEN-1:0] prod;
	} mul_stage_t;

endpackage

//--- logic/dispatch.sv
// Dispatch
// Takes the head micro-op of the instruction queue and steers it to
// the ALU or the multiply issue FIFO. Stalls while the chosen FIFO is full.

`timescale 1ns/1ps

module dispatch import backend_pkg::*; (
	input  logic      CLK,
	input  logic      i_rst,
	input  micro_op_t i_instr,
	input  logic      i_instr_empty,
	input  logic      i_alu_full,
	input  logic      i_mul_full,
	output logic      o_instr_pop,
	output logic      o_alu_push,
	output logic      o_mul_push,
	output micro_op_t o_uop
);

	logic run_q;
	logic is_mul;
	logic target_full;
	logic go;

	// Low through reset, high from the first cycle after it
	always_ff @(posedge CLK) begin
		if (i_rst) begin
			run_q <= 1'b0;
		end else begin
			run_q <= 1'b1;
		end
	end

	assign is_mul      = (i_instr.op == OP_MUL) || (i_instr.op == OP_MULH);
	assign target_full = is_mul ? i_mul_full : i_alu_full;

	// Only back-pressure point in the back end
	assign go = run_q & ~i_instr_empty & ~target_full;

	assign o_instr_pop = go;
	assign o_alu_push  = go & ~is_mul;
	assign o_mul_push  = go & is_mul;
	assign o_uop       = i_instr;

endmodule

//--- logic/issue_fifo.sv
// Issue FIFO
// Circular buffer of FIFO_DEPTH entries between dispatch and one lane.
// The head entry is presented combinationally on o_data.

`timescale 1ns/1ps

module issue_fifo import backend_pkg::*; #(
	parameter type T = micro_op_t
) (
	input  logic CLK,
	input  logic i_rst,
	input  logic i_push,
	input  T     i_data,
	input  logic i_pop,
	output T     o_data,
	output logic o_empty,
	output logic o_full
);

	T mem [FIFO_DEPTH];

	logic [FIFO_PW-1:0] wr_ptr;
	logic [FIFO_PW-1:0] rd_ptr;
	logic [FIFO_CW-1:0] count;
	logic do_push;
	logic do_pop;

	assign o_empty = (count == '0);
	assign o_full  = (count == FIFO_CW'(FIFO_DEPTH));
	assign o_data  = mem[rd_ptr];

	assign do_push = i_push & ~o_full;
	assign do_pop  = i_pop & ~o_empty;

	always_ff @(posedge CLK) begin
		if (i_rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			// Simultaneous push and pop leaves the count alone
			if (do_push && !do_pop) begin
				count <= count + 1'b1;
			end else if (do_pop && !do_push) begin
				count <= count - 1'b1;
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (do_push) begin
			mem[wr_ptr] <= i_data;
		end
	end

endmodule

//--- logic/alu_lane.sv
// ALU lane
// Drains the ALU issue FIFO one entry per cycle and registers
// a single-cycle integer result for writeback.

`timescale 1ns/1ps

module alu_lane import backend_pkg::*; (
	input  logic      CLK,
	input  logic      i_rst,
	input  micro_op_t i_uop,
	input  logic      i_empty,
	output logic      o_pop,
	output wb_t       o_wb
);

	xlen_t res;

	// Never stalls, so any waiting entry goes
	assign o_pop = ~i_empty;

	always_comb begin
		case (i_uop.op)
			OP_ADD:  res = i_uop.op_a + i_uop.op_b;
			OP_SUB:  res = i_uop.op_a - i_uop.op_b;
			OP_AND:  res = i_uop.op_a & i_uop.op_b;
			OP_OR:   res = i_uop.op_a | i_uop.op_b;
			OP_XOR:  res = i_uop.op_a ^ i_uop.op_b;
			OP_SLL:  res = i_uop.op_a << i_uop.op_b[4:0];
			default: res = '0;
		endcase
	end

	always_ff @(posedge CLK) begin
		if (i_rst) begin
			o_wb.valid <= 1'b0;
		end else begin
			o_wb.valid <= o_pop;
		end
	end

	always_ff @(posedge CLK) begin
		o_wb.rd   <= i_uop.rd;
		o_wb.data <= res;
	end

endmodule

//--- logic/mul_lane.sv
// Multiply lane
// Pops the multiply FIFO every cycle it holds work and pushes the
// unsigned 64-bit product down a MUL_STAGES deep pipeline. The low or
// high half is picked at the last stage.

`timescale 1ns/1ps

module mul_lane import backend_pkg::*; (
	input  logic      CLK,
	input  logic      i_rst,
	input  micro_op_t i_uop,
	input  logic      i_empty,
	output logic      o_pop,
	output wb_t       o_wb
);

	logic [MUL_STAGES-1:0] stage_vld;
	mul_stage_t            stage_q [MUL_STAGES];
	mul_stage_t            last;

	// Fully pipelined, no back-pressure
	assign o_pop = ~i_empty;

	always_ff @(posedge CLK) begin
		if (i_rst) begin
			stage_vld <= '0;
		end else begin
			stage_vld <= {stage_vld[MUL_STAGES-2:0], o_pop};
		end
	end

	// Product formed on entry, then only carried
	always_ff @(posedge CLK) begin
		stage_q[0].rd   <= i_uop.rd;
		stage_q[0].hi   <= (i_uop.op == OP_MULH);
		stage_q[0].prod <= (2*XLEN)'(i_uop.op_a) * (2*XLEN)'(i_uop.op_b);
		for (int i = 1; i < MUL_STAGES; i++) begin
			stage_q[i] <= stage_q[i-1];
		end
	end

	assign last = stage_q[MUL_STAGES-1];

	assign o_wb.valid = stage_vld[MUL_STAGES-1];
	assign o_wb.rd    = last.rd;
	assign o_wb.data  = last.hi ? last.prod[2*XLEN-1:XLEN] : last.prod[XLEN-1:0];

endmodule

//--- logic/writeback_regfile.sv
// Writeback and register file
// Applies the ALU and multiply writebacks in the same cycle, multiply
// first on a shared rd, and serves one combinational read port.
// Register 0 is never written.

`timescale 1ns/1ps

module writeback_regfile import backend_pkg::*; (
	input  logic      CLK,
	input  logic      i_rst,
	input  wb_t       i_alu_wb,
	input  wb_t       i_mul_wb,
	input  reg_addr_t i_rd_addr,
	output xlen_t     o_rd_data
);

	xlen_t regs [NUM_REGS];

	always_ff @(posedge CLK) begin
		if (i_rst) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else begin
			// Start at 1 so x0 keeps its reset value
			for (int i = 1; i < NUM_REGS; i++) begin
				if (i_mul_wb.valid && i_mul_wb.rd == reg_addr_t'(i)) begin
					regs[i] <= i_mul_wb.data;
				end else if (i_alu_wb.valid && i_alu_wb.rd == reg_addr_t'(i)) begin
					regs[i] <= i_alu_wb.data;
				end
			end
		end
	end

	assign o_rd_data = regs[i_rd_addr];

endmodule

//--- logic/backend_top.sv
// Execution back end
// Dispatch feeds two issue FIFOs; the ALU lane and the multiply lane
// drain them in parallel and writeback merges both into the
// register file.

`timescale 1ns/1ps

module backend_top import backend_pkg::*; (
	input  logic      CLK,
	input  logic      i_rst,
	input  micro_op_t i_instr,
	input  logic      i_instr_empty,
	output logic      o_instr_pop,
	input  reg_addr_t i_rd_addr,
	output xlen_t     o_rd_data
);

	micro_op_t uop;
	micro_op_t alu_head;
	micro_op_t mul_head;
	logic      alu_push;
	logic      mul_push;
	logic      alu_full;
	logic      mul_full;
	logic      alu_empty;
	logic      mul_empty;
	logic      alu_pop;
	logic      mul_pop;
	wb_t       alu_wb;
	wb_t       mul_wb;

	dispatch i_dispatch (
		.CLK          (CLK),
		.i_rst        (i_rst),
		.i_instr      (i_instr),
		.i_instr_empty(i_instr_empty),
		.i_alu_full   (alu_full),
		.i_mul_full   (mul_full),
		.o_instr_pop  (o_instr_pop),
		.o_alu_push   (alu_push),
		.o_mul_push   (mul_push),
		.o_uop        (uop)
	);

	issue_fifo #(.T(micro_op_t)) alu_fifo (
		.CLK    (CLK),
		.i_rst  (i_rst),
		.i_push (alu_push),
		.i_data (uop),
		.i_pop  (alu_pop),
		.o_data (alu_head),
		.o_empty(alu_empty),
		.o_full (alu_full)
	);

	issue_fifo #(.T(micro_op_t)) mul_fifo (
		.CLK    (CLK),
		.i_rst  (i_rst),
		.i_push (mul_push),
		.i_data (uop),
		.i_pop  (mul_pop),
		.o_data (mul_head),
		.o_empty(mul_empty),
		.o_full (mul_full)
	);

	alu_lane i_alu_lane (
		.CLK    (CLK),
		.i_rst  (i_rst),
		.i_uop  (alu_head),
		.i_empty(alu_empty),
		.o_pop  (alu_pop),
		.o_wb   (alu_wb)
	);

	mul_lane i_mul_lane (
		.CLK    (CLK),
		.i_rst  (i_rst),
		.i_uop  (mul_head),
		.i_empty(mul_empty),
		.o_pop  (mul_pop),
		.o_wb   (mul_wb)
	);

	writeback_regfile i_writeback_regfile (
		.CLK      (CLK),
		.i_rst    (i_rst),
		.i_alu_wb (alu_wb),
		.i_mul_wb (mul_wb),
		.i_rd_addr(i_rd_addr),
		.o_rd_data(o_rd_data)
	);

endmodule

//--- tb/backend_assertions.sv
// Back end assertions
// Bound into backend_top to watch the queue pop, both FIFO pushes
// and the multiply lane's pipeline latency.

`timescale 1ns/1ps

module backend_assertions import backend_pkg::*; (
	input logic CLK,
	input logic i_rst,
	input logic i_instr_empty,
	input logic i_instr_pop,
	input logic i_alu_push,
	input logic i_alu_full,
	input logic i_mul_push,
	input logic i_mul_full,
	input logic i_mul_pop,
	input logic i_mul_wb_valid
);

	// Pop only from a non-empty queue and never in reset
	ap_pop_ready: assert property (@(posedge CLK) i_instr_pop |-> (!i_instr_empty && !i_rst))
		else $error("instruction pop while queue empty or in reset");

	ap_alu_push: assert property (@(posedge CLK) disable iff (i_rst) i_alu_push |-> !i_alu_full)
		else $error("push into full ALU FIFO");

	ap_mul_push: assert property (@(posedge CLK) disable iff (i_rst) i_mul_push |-> !i_mul_full)
		else $error("push into full multiply FIFO");

	ap_mul_latency: assert property (@(posedge CLK) disable iff (i_rst)
		i_mul_wb_valid == $past(i_mul_pop, MUL_STAGES))
		else $error("multiply writeback valid out of step with its pop");

endmodule

bind backend_top backend_assertions i_backend_assertions (
	.CLK           (CLK),
	.i_rst         (i_rst),
	.i_instr_empty (i_instr_empty),
	.i_instr_pop   (o_instr_pop),
	.i_alu_push    (alu_push),
	.i_alu_full    (alu_full),
	.i_mul_push    (mul_push),
	.i_mul_full    (mul_full),
	.i_mul_pop     (mul_pop),
	.i_mul_wb_valid(mul_wb.valid)
);

//--- tb/tb_backend.sv
// Back end testbench
// Models the instruction queue, runs directed tests through the
// execution back end and reads results back over the register port.

`timescale 1ns/1ps

module tb_backend import backend_pkg::*;;

	// Tests need a few hundred cycles in total
	localparam int MAX_CYCLES = 2000;

	logic      CLK = 1'b0;
	logic      i_rst = 1'b1;
	micro_op_t i_instr = '0;
	logic      i_instr_empty = 1'b1;
	reg_addr_t i_rd_addr = '0;
	logic      o_instr_pop;
	xlen_t     o_rd_data;

	micro_op_t uop_q [128];
	logic [6:0] q_len = '0;
	logic [6:0] q_idx = '0;
	xlen_t     exp_regs [NUM_REGS];
	xlen_t     rng = 32'd21245;
	int        pass_count = 0;
	int        fail_count = 0;
	int        cycles = 0;

	backend_top i_backend_top (
		.CLK          (CLK),
		.i_rst        (i_rst),
		.i_instr      (i_instr),
		.i_instr_empty(i_instr_empty),
		.o_instr_pop  (o_instr_pop),
		.i_rd_addr    (i_rd_addr),
		.o_rd_data    (o_rd_data)
	);

	initial begin
		forever #4 CLK = ~CLK;
	end

	// Instruction queue model, head moves on each sampled pop
	always @(posedge CLK) begin
		logic [6:0] nxt;
		nxt = o_instr_pop ? q_idx + 7'd1 : q_idx;
		q_idx         <= nxt;
		i_instr       <= uop_q[nxt];
		i_instr_empty <= (nxt >= q_len);
	end

	always @(posedge CLK) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	function automatic xlen_t next_rand();
		rng = rng ^ (rng << 13);
		rng = rng ^ (rng >> 17);
		rng = rng ^ (rng << 5);
		return rng;
	endfunction

	// Expected result straight from the opcode rules
	function automatic xlen_t model_result(op_e op, xlen_t a, xlen_t b);
		logic [2*XLEN-1:0] prod;
		prod = {32'd0, a} * {32'd0, b};
		case (op)
			OP_ADD:  return a + b;
			OP_SUB:  return a - b;
			OP_AND:  return a & b;
			OP_OR:   return a | b;
			OP_XOR:  return a ^ b;
			OP_SLL:  return a << b[4:0];
			OP_MUL:  return prod[XLEN-1:0];
			default: return prod[2*XLEN-1:XLEN];
		endcase
	endfunction

	task automatic add_uop(input op_e op, input reg_addr_t rd, input xlen_t a, input xlen_t b);
		micro_op_t u;
		u.op   = op;
		u.rd   = rd;
		u.op_a = a;
		u.op_b = b;
		uop_q[q_len] = u;
		q_len = q_len + 7'd1;
		if (rd != '0) begin
			exp_regs[rd] = model_result(op, a, b);
		end
	endtask

	task automatic wait_drain();
		while (q_idx != q_len) begin
			@(negedge CLK);
		end
		repeat (8) @(negedge CLK);
	endtask

	task automatic check_data(input reg_addr_t addr, input xlen_t expected);
		@(posedge CLK);
		i_rd_addr <= addr;
		@(negedge CLK);
		if (o_rd_data !== expected) begin
			$display("Fail %0t: x%0d reads %h, expected %h", $time, addr, o_rd_data, expected);
			fail_count++;
		end else begin
			pass_count++;
		end
	endtask

	task automatic check_pop(input logic expected);
		@(negedge CLK);
		if (o_instr_pop !== expected) begin
			$display("Fail %0t: o_instr_pop is %b, expected %b", $time, o_instr_pop, expected);
			fail_count++;
		end else begin
			pass_count++;
		end
	endtask

	task automatic check_all_regs();
		for (int r = 0; r < NUM_REGS; r++) begin
			check_data(reg_addr_t'(r), exp_regs[reg_addr_t'(r)]);
		end
	endtask

	task automatic report_test(input string name, input int fails_before);
		$display("%s finished with %0d errors", name, fail_count - fails_before);
	endtask

	task automatic test_reset();
		int f0;
		f0 = fail_count;
		check_pop(1'b0);
		check_all_regs();
		report_test("reset", f0);
	endtask

	task automatic test_alu_ops();
		int f0;
		f0 = fail_count;
		@(negedge CLK);
		add_uop(OP_ADD, 4'd1, next_rand(), next_rand());
		add_uop(OP_SUB, 4'd2, next_rand(), next_rand());
		add_uop(OP_AND, 4'd3, next_rand(), next_rand());
		add_uop(OP_OR,  4'd4, next_rand(), next_rand());
		add_uop(OP_XOR, 4'd5, next_rand(), next_rand());
		add_uop(OP_SLL, 4'd6, next_rand(), next_rand());
		wait_drain();
		check_all_regs();
		report_test("alu_ops", f0);
	endtask

	task automatic test_mul_ops();
		int f0;
		xlen_t a;
		xlen_t b;
		f0 = fail_count;
		a = next_rand();
		b = next_rand();
		@(negedge CLK);
		add_uop(OP_MUL,  4'd7, a, b);
		add_uop(OP_MULH, 4'd8, a, b);
		add_uop(OP_MULH, 4'd10, 32'hffff_ffff, 32'hffff_ffff);
		wait_drain();
		check_all_regs();
		report_test("mul_ops", f0);
	endtask

	// Same rd only 15 ops apart, so lane order never matters
	task automatic test_stream();
		int f0;
		xlen_t r;
		f0 = fail_count;
		@(negedge CLK);
		for (int i = 0; i < 24; i++) begin
			r = next_rand();
			add_uop(op_e'(r[2:0]), reg_addr_t'((i % 15) + 1), next_rand(), next_rand());
		end
		wait_drain();
		check_all_regs();
		report_test("stream", f0);
	endtask

	task automatic test_reg_zero();
		int f0;
		f0 = fail_count;
		@(negedge CLK);
		add_uop(OP_ADD, 4'd0, next_rand(), next_rand());
		add_uop(OP_XOR, 4'd9, next_rand(), next_rand());
		wait_drain();
		check_data(4'd0, 32'd0);
		check_data(4'd9, exp_regs[4'd9]);
		report_test("reg_zero", f0);
	endtask

	initial begin
		for (int r = 0; r < NUM_REGS; r++) begin
			exp_regs[r] = '0;
		end
		// An op for x0 waits in the queue through reset
		add_uop(OP_ADD, 4'd0, next_rand(), next_rand());
		repeat (10) @(posedge CLK);
		i_rst <= 1'b0;
		test_reset();
		test_alu_ops();
		test_mul_ops();
		test_stream();
		test_reg_zero();
		$display("Checks passed: %0d, failed: %0d", pass_count, fail_count);
		if (fail_count == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

//--- backend.f
logic/backend_pkg.sv
logic/dispatch.sv
logic/issue_fifo.sv
logic/alu_lane.sv
logic/mul_lane.sv
logic/writeback_regfile.sv
logic/backend_top.sv
tb/backend_assertions.sv
tb/tb_backend.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the back end testbench with Verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -f backend.f --top-module tb_backend -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/Vtb_backend > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "TEST RESULT: FAIL" "$LOG"; then
	echo "Simulation reported failure, see $LOG"
	exit 1
fi
exit 0
